//--- Bender.yml
package:
  name: rv_core

sources:
  - hdl/rv_pkg.sv
  - hdl/rv_decoder.sv
  - hdl/rv_regfile.sv
  - hdl/rv_alu.sv
  - hdl/rv_divider.sv
  - hdl/rv_lsu.sv
  - hdl/rv_core.sv
  - target: test
    files:
      - test/tb_rv_core.sv

//--- hdl/rv_alu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
    input  wire rv_pkg::ctrl_t i_ctrl,
    input  wire rv_pkg::word_t i_pc,
    input  wire rv_pkg::word_t i_rs1,
    input  wire rv_pkg::word_t i_rs2,
    output rv_pkg::word_t      o_result,
    output rv_pkg::word_t      o_next_pc
);

    localparam int SHAMT_W = $clog2(rv_pkg::XLEN);

    rv_pkg::word_t      opb;
    rv_pkg::word_t      pc_plus4;
    rv_pkg::word_t      jalr_sum;
    logic [SHAMT_W-1:0] shamt;
    logic               eq, lt, ltu;
    logic               taken;

    assign opb      = i_ctrl.use_imm ? i_ctrl.imm : i_rs2;   // branches keep rs2
    assign shamt    = opb[SHAMT_W-1:0];
    assign pc_plus4 = i_pc + 4;
    assign jalr_sum = i_rs1 + i_ctrl.imm;

    assign eq  = (i_rs1 == opb);
    assign lt  = ($signed(i_rs1) < $signed(opb));
    assign ltu = (i_rs1 < opb);

    always_comb begin
        case (i_ctrl.alu_op)
            rv_pkg::ALU_SUB:      o_result = i_rs1 - opb;
            rv_pkg::ALU_AND:      o_result = i_rs1 & opb;
            rv_pkg::ALU_OR:       o_result = i_rs1 | opb;
            rv_pkg::ALU_XOR:      o_result = i_rs1 ^ opb;
            rv_pkg::ALU_SLL:      o_result = i_rs1 << shamt;
            rv_pkg::ALU_SRL:      o_result = i_rs1 >> shamt;
            rv_pkg::ALU_SRA:      o_result = $signed(i_rs1) >>> shamt;
            rv_pkg::ALU_SLT:      o_result = rv_pkg::word_t'(lt);
            rv_pkg::ALU_SLTU:     o_result = rv_pkg::word_t'(ltu);
            rv_pkg::ALU_PASS_IMM: o_result = i_ctrl.imm;
            rv_pkg::ALU_PC_IMM:   o_result = i_pc + i_ctrl.imm;
            rv_pkg::ALU_LINK:     o_result = pc_plus4;
            default:              o_result = i_rs1 + opb;   // add, load/store address
        endcase
    end

    always_comb begin
        case (i_ctrl.branch)
            rv_pkg::BR_EQ:  taken = eq;
            rv_pkg::BR_NE:  taken = !eq;
            rv_pkg::BR_LT:  taken = lt;
            rv_pkg::BR_GE:  taken = !lt;
            rv_pkg::BR_LTU: taken = ltu;
            rv_pkg::BR_GEU: taken = !ltu;
            default:        taken = 1'b0;
        endcase
    end

    always_comb begin
        if (i_ctrl.is_jalr)
            o_next_pc = {jalr_sum[rv_pkg::XLEN-1:1], 1'b0};
        else if (i_ctrl.is_jal || taken)
            o_next_pc = i_pc + i_ctrl.imm;
        else
            o_next_pc = pc_plus4;
    end

endmodule

`default_nettype wire

//--- hdl/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core (
    input  wire logic          clk,
    input  wire logic          clrn,
    input  wire rv_pkg::word_t i_inst,
    input  wire rv_pkg::word_t i_mem,
    output rv_pkg::word_t      o_pc,
    output rv_pkg::word_t      o_alu_out,
    output rv_pkg::word_t      o_store_data,
    output logic [3:0]         o_wmem
);

    rv_pkg::ctrl_t ctrl;
    rv_pkg::word_t rs1_data, rs2_data;
    rv_pkg::word_t alu_result, next_pc;
    rv_pkg::word_t div_result, load_data, wb_data;
    logic [3:0]    lsu_wmem;
    logic          busy;

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn)
            o_pc <= '0;
        else if (!busy)                                // held while dividing
            o_pc <= next_pc;
    end

    assign o_alu_out = ctrl.is_div ? div_result : alu_result;
    assign wb_data   = ctrl.is_load ? load_data : o_alu_out;
    assign o_wmem    = (busy || !clrn) ? 4'b0000 : lsu_wmem;   // quiet in reset too

    rv_decoder u_decoder (.i_inst(i_inst), .o_ctrl(ctrl));

    rv_regfile u_regfile (
        .clk, .clrn, .i_ctrl(ctrl), .i_we(ctrl.wreg & ~busy), .i_wdata(wb_data),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
    );

    rv_alu u_alu (
        .i_ctrl(ctrl), .i_pc(o_pc), .i_rs1(rs1_data), .i_rs2(rs2_data),
        .o_result(alu_result), .o_next_pc(next_pc)
    );

    rv_divider #(.WIDTH(rv_pkg::XLEN)) u_divider (
        .clk, .clrn, .i_ctrl(ctrl), .i_dividend(rs1_data), .i_divisor(rs2_data),
        .o_result(div_result), .o_busy(busy)
    );

    rv_lsu u_lsu (
        .i_ctrl(ctrl), .i_addr(alu_result), .i_mem(i_mem), .i_rs2(rs2_data),
        .o_load_data(load_data), .o_store_data(o_store_data), .o_wmem(lsu_wmem)
    );

endmodule

`default_nettype wire

//--- hdl/rv_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decoder (
    input  wire rv_pkg::word_t i_inst,
    output rv_pkg::ctrl_t      o_ctrl
);

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    logic          alt;
    rv_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];
    assign alt    = (funct7 == rv_pkg::FUNCT7_ALT);

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'h000};
    assign imm_j = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    function automatic rv_pkg::alu_op_e f3_op(input logic [2:0] f3, input logic sel_alt);
        case (f3)
            3'b000:  f3_op = sel_alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  f3_op = rv_pkg::ALU_SLL;
            3'b010:  f3_op = rv_pkg::ALU_SLT;
            3'b011:  f3_op = rv_pkg::ALU_SLTU;
            3'b100:  f3_op = rv_pkg::ALU_XOR;
            3'b101:  f3_op = sel_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  f3_op = rv_pkg::ALU_OR;
            default: f3_op = rv_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        o_ctrl     = '0;                               // unknown opcodes stay a nop
        o_ctrl.rd  = i_inst[11:7];
        o_ctrl.rs1 = i_inst[19:15];
        o_ctrl.rs2 = i_inst[24:20];
        case (opcode)
            rv_pkg::OPC_LUI: begin
                o_ctrl.alu_op = rv_pkg::ALU_PASS_IMM;
                o_ctrl.imm    = imm_u;
                o_ctrl.wreg   = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                o_ctrl.alu_op = rv_pkg::ALU_PC_IMM;
                o_ctrl.imm    = imm_u;
                o_ctrl.wreg   = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                o_ctrl.alu_op = rv_pkg::ALU_LINK;
                o_ctrl.imm    = imm_j;
                o_ctrl.is_jal = 1'b1;
                o_ctrl.wreg   = 1'b1;
            end
            rv_pkg::OPC_JALR: begin
                o_ctrl.alu_op  = rv_pkg::ALU_LINK;
                o_ctrl.imm     = imm_i;
                o_ctrl.is_jalr = (funct3 == 3'b000);
                o_ctrl.wreg    = (funct3 == 3'b000);
            end
            rv_pkg::OPC_BRANCH: begin
                o_ctrl.imm = imm_b;
                case (funct3)
                    3'b000:  o_ctrl.branch = rv_pkg::BR_EQ;
                    3'b001:  o_ctrl.branch = rv_pkg::BR_NE;
                    3'b100:  o_ctrl.branch = rv_pkg::BR_LT;
                    3'b101:  o_ctrl.branch = rv_pkg::BR_GE;
                    3'b110:  o_ctrl.branch = rv_pkg::BR_LTU;
                    3'b111:  o_ctrl.branch = rv_pkg::BR_GEU;
                    default: o_ctrl.branch = rv_pkg::BR_NONE;
                endcase
            end
            rv_pkg::OPC_LOAD: begin
                o_ctrl.imm           = imm_i;
                o_ctrl.use_imm       = 1'b1;
                o_ctrl.mem_size      = rv_pkg::mem_size_e'(funct3[1:0]);
                o_ctrl.load_unsigned = funct3[2];
                o_ctrl.is_load       = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
                o_ctrl.wreg          = o_ctrl.is_load;
            end
            rv_pkg::OPC_STORE: begin
                o_ctrl.imm      = imm_s;
                o_ctrl.use_imm  = 1'b1;
                o_ctrl.mem_size = rv_pkg::mem_size_e'(funct3[1:0]);
                o_ctrl.is_store = !funct3[2] && (funct3[1:0] != 2'b11);
            end
            rv_pkg::OPC_OP_IMM: begin
                o_ctrl.imm     = imm_i;
                o_ctrl.use_imm = 1'b1;
                o_ctrl.alu_op  = f3_op(funct3, alt && (funct3 == 3'b101));
                if (funct3 == 3'b001)
                    o_ctrl.wreg = (funct7 == 7'd0);
                else if (funct3 == 3'b101)
                    o_ctrl.wreg = (funct7 == 7'd0) || alt;
                else
                    o_ctrl.wreg = 1'b1;
            end
            rv_pkg::OPC_OP: begin
                if (funct7 == rv_pkg::FUNCT7_MULDIV) begin // only div/rem kept
                    o_ctrl.is_div     = funct3[2];
                    o_ctrl.wreg       = funct3[2];
                    o_ctrl.div_signed = !funct3[0];
                    o_ctrl.div_rem    = funct3[1];
                end else begin
                    o_ctrl.alu_op = f3_op(funct3, alt);
                    o_ctrl.wreg   = (funct7 == 7'd0) ||
                                    (alt && (funct3 == 3'b000 || funct3 == 3'b101));
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/rv_divider.sv
`timescale 1ns/10ps
`default_nettype none

module rv_divider #(
    parameter int WIDTH = 32
) (
    input  wire logic          clk,
    input  wire logic          clrn,
    input  wire rv_pkg::ctrl_t i_ctrl,
    input  wire rv_pkg::word_t i_dividend,
    input  wire rv_pkg::word_t i_divisor,
    output rv_pkg::word_t      o_result,
    output logic               o_busy
);

    localparam int               CNT_W = $clog2(WIDTH + 2);
    localparam logic [CNT_W-1:0] LAST  = CNT_W'(WIDTH + 1);   // sign-fix cycle

    logic [CNT_W-1:0] cnt;
    logic [WIDTH-1:0] a, b;
    logic             sa, sb;
    logic [WIDTH-1:0] mag_a, mag_b;
    logic [WIDTH-1:0] quo, rem, dvs;
    logic             neg_q, neg_r;
    logic [WIDTH:0]   rem_shift, diff;
    logic             ge;
    logic [WIDTH-1:0] q_out, r_out;

    assign a     = i_dividend[WIDTH-1:0];
    assign b     = i_divisor[WIDTH-1:0];
    assign sa    = i_ctrl.div_signed & a[WIDTH-1];
    assign sb    = i_ctrl.div_signed & b[WIDTH-1];
    assign mag_a = sa ? -a : a;
    assign mag_b = sb ? -b : b;

    // one restoring step with quotient bits shifting in from the right
    assign rem_shift = {rem, quo[WIDTH-1]};
    assign ge        = (rem_shift >= {1'b0, dvs});
    assign diff      = rem_shift - {1'b0, dvs};

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            cnt   <= '0;
            quo   <= '0;
            rem   <= '0;
            dvs   <= '0;
            neg_q <= 1'b0;
            neg_r <= 1'b0;
        end else if (i_ctrl.is_div) begin
            if (cnt == '0) begin                       // load magnitudes
                quo   <= mag_a;
                rem   <= '0;
                dvs   <= mag_b;
                neg_q <= (sa ^ sb) && (b != '0);       // x/0 keeps all ones
                neg_r <= sa;
                cnt   <= CNT_W'(1);
            end else if (cnt == LAST) begin
                cnt <= '0;
            end else begin
                quo <= (quo << 1) | WIDTH'(ge);
                rem <= ge ? diff[WIDTH-1:0] : rem_shift[WIDTH-1:0];
                cnt <= cnt + 1'b1;
            end
        end
    end

    // signed overflow comes out as 2^(W-1) / 1 with no special case
    assign q_out    = neg_q ? -quo : quo;
    assign r_out    = neg_r ? -rem : rem;
    assign o_result = rv_pkg::word_t'(i_ctrl.div_rem ? r_out : q_out);
    assign o_busy   = i_ctrl.is_div && (cnt != LAST);

    a_busy_bounded: assert property (@(posedge clk) disable iff (!clrn)
        not (o_busy [* WIDTH+2]));

endmodule

`default_nettype wire

//--- hdl/rv_lsu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_lsu (
    input  wire rv_pkg::ctrl_t i_ctrl,
    input  wire rv_pkg::word_t i_addr,
    input  wire rv_pkg::word_t i_mem,
    input  wire rv_pkg::word_t i_rs2,
    output rv_pkg::word_t      o_load_data,
    output rv_pkg::word_t      o_store_data,
    output logic [3:0]         o_wmem
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic        ext;
    logic [3:0]  strobe;

    assign byte_sel = i_mem[8*i_addr[1:0] +: 8];
    assign half_sel = i_mem[16*i_addr[1] +: 16];
    assign ext      = !i_ctrl.load_unsigned;

    always_comb begin
        case (i_ctrl.mem_size)
            rv_pkg::MEM_BYTE: o_load_data = {{(rv_pkg::XLEN-8){ext & byte_sel[7]}}, byte_sel};
            rv_pkg::MEM_HALF: o_load_data = {{(rv_pkg::XLEN-16){ext & half_sel[15]}}, half_sel};
            default:          o_load_data = i_mem;
        endcase
    end

    always_comb begin
        case (i_ctrl.mem_size)
            rv_pkg::MEM_BYTE: begin
                o_store_data = {4{i_rs2[7:0]}};        // same byte in every lane
                strobe       = 4'b0001 << i_addr[1:0];
            end
            rv_pkg::MEM_HALF: begin
                o_store_data = {2{i_rs2[15:0]}};
                strobe       = 4'b0011 << {i_addr[1], 1'b0};
            end
            default: begin
                o_store_data = i_rs2;
                strobe       = 4'b1111;
            end
        endcase
    end

    assign o_wmem = i_ctrl.is_store ? strobe : 4'b0000;

endmodule

`default_nettype wire

//--- hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    localparam logic [6:0] OPC_OP     = 7'b0110011;    // register-register
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;    // register-immediate
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000; // sub, sra
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001; // rv32m

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU,
        ALU_PASS_IMM,                                  // lui
        ALU_PC_IMM,                                    // auipc
        ALU_LINK                                       // pc + 4
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } branch_e;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;                            // operand b is imm
        word_t     imm;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        logic      wreg;
        logic      is_load;
        logic      is_store;
        logic      load_unsigned;
        mem_size_e mem_size;
        branch_e   branch;
        logic      is_jal;
        logic      is_jalr;
        logic      is_div;
        logic      div_signed;
        logic      div_rem;                            // rem/remu
    } ctrl_t;

endpackage

`default_nettype wire

//--- hdl/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
    input  wire logic          clk,
    input  wire logic          clrn,
    input  wire rv_pkg::ctrl_t i_ctrl,
    input  wire logic          i_we,
    input  wire rv_pkg::word_t i_wdata,
    output rv_pkg::word_t      o_rs1_data,
    output rv_pkg::word_t      o_rs2_data
);

    rv_pkg::word_t [2**rv_pkg::REG_ADDR_W-1:1] regs;  // x0 is not stored

    assign o_rs1_data = (i_ctrl.rs1 == '0) ? '0 : regs[i_ctrl.rs1];
    assign o_rs2_data = (i_ctrl.rs2 == '0) ? '0 : regs[i_ctrl.rs2];

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            regs <= '0;
        end else if (i_we && i_ctrl.rd != '0) begin
            regs[i_ctrl.rd] <= i_wdata;
        end
    end

endmodule

`default_nettype wire

//--- sources.f
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_divider.sv
hdl/rv_lsu.sv
hdl/rv_core.sv
test/tb_rv_core.sv

//--- test/tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

    localparam int XLEN    = rv_pkg::XLEN;
    localparam int TIMEOUT = XLEN + 10;
    localparam int N_RAND  = 3000;

    // one instruction as chosen by the generator, before encoding
    typedef struct packed {
        logic [6:0]       opc;
        logic [2:0]       f3;
        logic             alt;                         // sub, sra, srai
        logic             muldiv;
        rv_pkg::reg_idx_t rd;
        rv_pkg::reg_idx_t rs1;
        rv_pkg::reg_idx_t rs2;
        rv_pkg::word_t    imm;
    } fields_t;

    logic          clk;
    logic          clrn;
    rv_pkg::word_t i_inst;
    rv_pkg::word_t i_mem;
    rv_pkg::word_t o_pc;
    rv_pkg::word_t o_alu_out;
    rv_pkg::word_t o_store_data;
    logic [3:0]    o_wmem;

    rv_pkg::word_t regs_m [32];
    rv_pkg::word_t mem [256];                          // aliased by addr[9:2]
    rv_pkg::word_t pc_m;
    rv_pkg::word_t exp_next, exp_out, exp_wdata, exp_addr, exp_sdata;
    logic [3:0]    exp_strb;
    logic          exp_wr, exp_chk, exp_div;
    logic [4:0]    exp_rd;
    logic [31:0]   rng_state;

    rv_core UUT (
        .clk, .clrn, .i_inst(i_inst), .i_mem(i_mem), .o_pc(o_pc),
        .o_alu_out(o_alu_out), .o_store_data(o_store_data), .o_wmem(o_wmem)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic check_word(input rv_pkg::word_t got, input rv_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_strobe(input logic [3:0] got, input logic [3:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    function automatic rv_pkg::word_t lane_mask(input logic [3:0] s);
        return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    function automatic fields_t make(input logic [6:0] opc, input logic [2:0] f3,
                                     input rv_pkg::reg_idx_t rd, input rv_pkg::reg_idx_t rs1,
                                     input rv_pkg::reg_idx_t rs2, input rv_pkg::word_t imm);
        fields_t f;
        f = '0;
        f.opc = opc;
        f.f3  = f3;
        f.rd  = rd;
        f.rs1 = rs1;
        f.rs2 = rs2;
        f.imm = imm;
        return f;
    endfunction

    function automatic rv_pkg::word_t encode(input fields_t f);
        logic [6:0] f7;
        f7 = f.muldiv ? 7'b0000001 : (f.alt ? 7'b0100000 : 7'b0000000);
        case (f.opc)
            rv_pkg::OPC_OP:
                return {f7, f.rs2, f.rs1, f.f3, f.rd, f.opc};
            rv_pkg::OPC_OP_IMM: begin
                if (f.f3 == 3'b001 || f.f3 == 3'b101)  // shamt form
                    return {f7, f.imm[4:0], f.rs1, f.f3, f.rd, f.opc};
                return {f.imm[11:0], f.rs1, f.f3, f.rd, f.opc};
            end
            rv_pkg::OPC_LOAD, rv_pkg::OPC_JALR:
                return {f.imm[11:0], f.rs1, f.f3, f.rd, f.opc};
            rv_pkg::OPC_STORE:
                return {f.imm[11:5], f.rs2, f.rs1, f.f3, f.imm[4:0], f.opc};
            rv_pkg::OPC_BRANCH:
                return {f.imm[12], f.imm[10:5], f.rs2, f.rs1, f.f3, f.imm[4:1], f.imm[11], f.opc};
            rv_pkg::OPC_JAL:
                return {f.imm[20], f.imm[10:1], f.imm[11], f.imm[19:12], f.rd, f.opc};
            default:
                return {f.imm[31:12], f.rd, f.opc};    // lui, auipc
        endcase
    endfunction

    function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                              input rv_pkg::word_t a, input rv_pkg::word_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input rv_pkg::word_t a,
                                          input rv_pkg::word_t b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic rv_pkg::word_t load_value(input logic [2:0] f3, input rv_pkg::word_t w,
                                                 input logic [1:0] off);
        logic [7:0]  bt;
        logic [15:0] hw;
        bt = 8'(w >> (8 * off));
        hw = 16'(w >> (16 * off[1]));
        case (f3)
            3'b000: return {{24{bt[7]}}, bt};
            3'b001: return {{16{hw[15]}}, hw};
            3'b100: return {24'h0, bt};
            3'b101: return {16'h0, hw};
            default: return w;
        endcase
    endfunction

    function automatic rv_pkg::word_t div_ref(input logic [2:0] f3, input rv_pkg::word_t a,
                                              input rv_pkg::word_t b);
        rv_pkg::word_t q, r;
        int            sa, sb;
        sa = a;
        sb = b;
        if (b == '0) begin                             // divide by zero
            q = '1;
            r = a;
        end else if (!f3[0] && a == 32'h8000_0000 && b == '1) begin
            q = a;                                     // signed overflow
            r = '0;
        end else if (!f3[0]) begin
            q = sa / sb;
            r = sa % sb;
        end else begin
            q = a / b;
            r = a % b;
        end
        return f3[1] ? r : q;
    endfunction

    task automatic predict(input fields_t f);
        rv_pkg::word_t a, b;
        a         = regs_m[f.rs1];
        b         = regs_m[f.rs2];
        exp_next  = pc_m + 4;
        exp_rd    = f.rd;
        exp_wr    = 1'b1;
        exp_chk   = 1'b1;
        exp_div   = 1'b0;
        exp_strb  = 4'h0;
        exp_sdata = '0;
        exp_addr  = '0;
        exp_out   = '0;
        case (f.opc)
            rv_pkg::OPC_LUI:    exp_out = f.imm;
            rv_pkg::OPC_AUIPC:  exp_out = pc_m + f.imm;
            rv_pkg::OPC_JAL: begin
                exp_out  = pc_m + 4;
                exp_next = pc_m + f.imm;
            end
            rv_pkg::OPC_JALR: begin
                exp_out  = pc_m + 4;
                exp_next = (a + f.imm) & ~32'd1;
            end
            rv_pkg::OPC_BRANCH: begin
                exp_wr   = 1'b0;
                exp_chk  = 1'b0;
                exp_next = branch_taken(f.f3, a, b) ? pc_m + f.imm : pc_m + 4;
            end
            rv_pkg::OPC_LOAD: begin
                exp_addr = a + f.imm;
                exp_out  = exp_addr;
            end
            rv_pkg::OPC_STORE: begin
                exp_wr   = 1'b0;
                exp_addr = a + f.imm;
                exp_out  = exp_addr;
                case (f.f3[1:0])
                    2'b00: begin
                        exp_strb  = 4'b0001 << exp_addr[1:0];
                        exp_sdata = b << (8 * exp_addr[1:0]);
                    end
                    2'b01: begin
                        exp_strb  = 4'b0011 << (2 * exp_addr[1]);
                        exp_sdata = b << (16 * exp_addr[1]);
                    end
                    default: begin
                        exp_strb  = 4'b1111;
                        exp_sdata = b;
                    end
                endcase
            end
            rv_pkg::OPC_OP_IMM: exp_out = alu_ref(f.f3, f.alt, a, f.imm);
            default: begin
                exp_div = f.muldiv;
                exp_out = f.muldiv ? div_ref(f.f3, a, b) : alu_ref(f.f3, f.alt, a, b);
            end
        endcase
        exp_wdata = exp_out;
        if (f.opc == rv_pkg::OPC_LOAD)
            exp_wdata = load_value(f.f3, mem[exp_addr[9:2]], exp_addr[1:0]);
    endtask

    function automatic fields_t gen_fields();
        fields_t     f;
        logic [31:0] r1, r2;
        r1    = xorshift32();
        r2    = xorshift32();
        f     = '0;
        f.rd  = 5'(r1 % 29);                           // x29..x31 stay fixed
        f.rs1 = r1[20:16];
        f.rs2 = r1[25:21];
        f.f3  = r1[28:26];
        f.alt = r1[29];
        f.imm = {{20{r2[11]}}, r2[11:0]};
        case (r1[3:0])
            4'd0, 4'd1, 4'd2, 4'd3: begin
                f.opc = rv_pkg::OPC_OP;
                f.alt = f.alt && (f.f3 == 3'b000 || f.f3 == 3'b101);
            end
            4'd4, 4'd5, 4'd6: begin
                f.opc = rv_pkg::OPC_OP_IMM;
                f.alt = f.alt && (f.f3 == 3'b101);
                if (f.f3 == 3'b001 || f.f3 == 3'b101)
                    f.imm = r2 % 32;
            end
            4'd7: begin
                f.opc = r1[30] ? rv_pkg::OPC_LUI : rv_pkg::OPC_AUIPC;
                f.imm = {r2[31:12], 12'h000};
            end
            4'd8: begin
                f.opc = rv_pkg::OPC_BRANCH;
                f.imm = {{19{r2[12]}}, r2[12:1], 1'b0};
                if (f.f3[2:1] == 2'b01)
                    f.f3[2] = 1'b1;
                if (r1[30])
                    f.rs2 = f.rs1;                     // makes equal operands likely
            end
            4'd9: begin
                f.opc = r1[30] ? rv_pkg::OPC_JAL : rv_pkg::OPC_JALR;
                f.f3  = 3'b000;
                if (r1[30])
                    f.imm = {{11{r2[20]}}, r2[20:1], 1'b0};
            end
            4'd10, 4'd11, 4'd12, 4'd13: begin
                f.opc = r1[1] ? rv_pkg::OPC_STORE : rv_pkg::OPC_LOAD;
                f.rs1 = 5'd31;                         // data base register
                if (f.f3[1:0] == 2'b11)
                    f.f3[1:0] = 2'b10;
                if (r1[1] || f.f3[1])
                    f.f3[2] = 1'b0;
                f.imm = f.imm & ~((32'd1 << f.f3[1:0]) - 32'd1);
            end
            default: begin
                f.opc    = rv_pkg::OPC_OP;
                f.muldiv = 1'b1;
                f.f3     = {1'b1, r1[27:26]};
                if (r2[1:0] == 2'd0)
                    f.rs2 = 5'd0;                      // divide by zero
                else if (r2[1:0] == 2'd1) begin
                    f.rs1 = 5'd29;                     // most negative / -1
                    f.rs2 = 5'd30;
                end
            end
        endcase
        return f;
    endfunction

    task automatic execute(input fields_t f);
        int held;
        int k;
        predict(f);
        i_inst = encode(f);
        i_mem  = mem[exp_addr[9:2]];
        held   = 0;
        #1;
        check_word(o_pc, pc_m, "pc");
        while (o_pc == pc_m) begin
            if (held > TIMEOUT) begin
                $display("pc did not advance from %h within %0d cycles", o_pc, TIMEOUT);
                abort_run();
            end
            check_strobe(o_wmem, exp_strb, "byte strobe");
            if (exp_chk && (!exp_div || held == XLEN + 1))
                check_word(o_alu_out, exp_out, "alu out");
            if (exp_strb != 4'h0)
                check_word(o_store_data & lane_mask(exp_strb), exp_sdata & lane_mask(exp_strb),
                           "store data");
            for (k = 0; k < 4; k++)
                if (o_wmem[k])
                    mem[o_alu_out[9:2]][8*k +: 8] = o_store_data[8*k +: 8];
            @(posedge clk);
            #1;
            held++;
        end
        check_word(rv_pkg::word_t'(held), rv_pkg::word_t'(exp_div ? XLEN + 2 : 1),
                   "cycles with pc held");
        check_word(o_pc, exp_next, "next pc");
        if (exp_wr && exp_rd != 5'd0)
            regs_m[exp_rd] = exp_wdata;
        pc_m = exp_next;
        @(negedge clk);
    endtask

    initial begin
        fields_t f;
        int      n;
        clk       = 1'b0;
        clrn      = 1'b0;
        i_inst    = encode(make(rv_pkg::OPC_STORE, 3'b010, 5'd0, 5'd0, 5'd0, 32'd8));  // store in reset
        i_mem     = '0;
        pc_m      = '0;
        rng_state = 32'ha5dd_fa90;
        for (n = 0; n < 32; n++)
            regs_m[n] = '0;
        for (n = 0; n < 256; n++)
            mem[n] = (n * 32'h9e37_79b9) ^ 32'h5bd1_e995;

        repeat (3) @(posedge clk);
        #1;
        check_word(o_pc, '0, "pc during reset");
        check_strobe(o_wmem, 4'h0, "byte strobe during reset");
        @(negedge clk);
        clrn = 1'b1;

        for (n = 1; n < 32; n++)                       // or x0, xn, xn
            execute(make(rv_pkg::OPC_OP, 3'b110, 5'd0, 5'(n), 5'(n), '0));
        execute(make(rv_pkg::OPC_STORE, 3'b010, 5'd0, 5'd0, 5'd0, 32'd8));

        execute(make(rv_pkg::OPC_LUI, 3'b000, 5'd31, 5'd0, 5'd0, 32'h1234_5000));
        execute(make(rv_pkg::OPC_OP_IMM, 3'b000, 5'd31, 5'd31, 5'd0, 32'hffff_fc00));
        execute(make(rv_pkg::OPC_LUI, 3'b000, 5'd29, 5'd0, 5'd0, 32'h8000_0000));
        execute(make(rv_pkg::OPC_OP_IMM, 3'b000, 5'd30, 5'd0, 5'd0, 32'hffff_ffff));

        for (n = 0; n < N_RAND; n++) begin
            do begin                                   // skip jumps onto the same pc
                f = gen_fields();
                predict(f);
            end while (!exp_div && exp_next == pc_m);
            execute(f);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
